/* verilog/rv32i_config.svh */
`ifndef RV32I_CONFIG_SVH
`define RV32I_CONFIG_SVH

// datapath width
`define XLEN 32

// integer register file
`define RF_COUNT 32
`define RF_IDX_W 5

`endif

/* verilog/rv32i_types.sv */
`default_nettype none

`include "rv32i_config.svh"

package rv32i_types;

	typedef logic [`XLEN-1:0]     word_t;
	typedef logic [`RF_IDX_W-1:0] reg_idx_t;

	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_auipc = 7'b0010111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	// slots 010/011 reuse the funct3 codes of slt/sltu
	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sll = 3'b001,
		alu_sra = 3'b010,
		alu_sub = 3'b011,
		alu_xor = 3'b100,
		alu_srl = 3'b101,
		alu_or  = 3'b110,
		alu_and = 3'b111
	} alu_ops;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3_t;

	typedef enum logic [2:0] {
		lb  = 3'b000,
		lh  = 3'b001,
		lw  = 3'b010,
		lbu = 3'b100,
		lhu = 3'b101
	} load_funct3_t;

	typedef enum logic [2:0] {
		sb = 3'b000,
		sh = 3'b001,
		sw = 3'b010
	} store_funct3_t;

	typedef enum logic [2:0] {
		add  = 3'b000, // add/sub
		sll  = 3'b001,
		slt  = 3'b010,
		sltu = 3'b011,
		axor = 3'b100,
		sr   = 3'b101, // srl/sra
		aor  = 3'b110,
		aand = 3'b111
	} arith_funct3_t;

	typedef struct packed {
		rv32i_opcode    opcode;
		logic           load_regfile;
		alu_ops         aluop;
		branch_funct3_t cmpop;
		logic [2:0]     regfilemux_sel; // alu, cmp, u-imm, load, pc+4
		logic           pcmux_sel;      // jump target
		logic           alumux1_sel;    // rs1 or pc
		logic [2:0]     alumux2_sel;    // i, u, b, s, rs2, j
		logic           cmpmux_sel;     // rs2 or i-imm
		logic [1:0]     store_type;     // 0 word, 1 byte, 2 half
		logic [1:0]     load_type;
		logic           load_unsigned;
		logic           write;
		logic           read_b;
	} rv32i_control_word;

	typedef struct packed {
		word_t       pc;
		logic [31:0] instr;
	} instr_in_t;

	typedef struct packed {
		word_t             pc;
		rv32i_control_word ctrl;
		word_t             rs1_val;
		word_t             rs2_val;
		word_t             i_imm;
		word_t             s_imm;
		word_t             b_imm;
		word_t             u_imm;
		word_t             j_imm;
		reg_idx_t          rd;
	} dx_t;

	typedef struct packed {
		word_t      pc;
		word_t      next_pc;
		reg_idx_t   rd;
		logic       rd_we;
		word_t      rd_wdata;
		logic       mem_read;
		logic       mem_write;
		word_t      mem_addr;
		word_t      mem_wdata;
		logic [3:0] mem_wmask;
		logic [1:0] load_type;
		logic       load_unsigned;
	} retire_t;

	typedef struct packed {
		logic     we;
		reg_idx_t rd;
		word_t    data;
	} rf_wr_t;

endpackage : rv32i_types

`default_nettype wire

/* verilog/control_rom.sv */
`default_nettype none
`timescale 1ns/1ps

module control_rom (
	input  wire rv32i_types::rv32i_opcode opcode,
	input  wire logic [2:0]               funct3,
	input  wire logic [6:0]               funct7,
	output rv32i_types::rv32i_control_word ctrl
);
	import rv32i_types::*;

	always_comb begin
		// defaults that most ops only partly override
		ctrl.opcode         = opcode;
		ctrl.load_regfile   = 1'b0;
		ctrl.aluop          = alu_ops'(funct3);
		ctrl.cmpop          = branch_funct3_t'(funct3);
		ctrl.regfilemux_sel = 3'd0;
		ctrl.pcmux_sel      = 1'b0;
		ctrl.alumux1_sel    = 1'b0;
		ctrl.alumux2_sel    = 3'd0;
		ctrl.cmpmux_sel     = 1'b0;
		ctrl.store_type     = 2'd0;
		ctrl.load_type      = 2'd0;
		ctrl.load_unsigned  = 1'b0;
		ctrl.write          = 1'b0;
		ctrl.read_b         = 1'b0;

		case (opcode)
			op_lui: begin
				ctrl.load_regfile   = 1'b1;
				ctrl.regfilemux_sel = 3'd2; // u-imm straight through
			end

			op_auipc: begin
				ctrl.load_regfile = 1'b1;
				ctrl.aluop        = alu_add;
				ctrl.alumux1_sel  = 1'b1;
				ctrl.alumux2_sel  = 3'd1;
			end

			op_jal: begin
				ctrl.load_regfile   = 1'b1;
				ctrl.regfilemux_sel = 3'd4; // link
				ctrl.pcmux_sel      = 1'b1;
				ctrl.alumux1_sel    = 1'b1; // pc + j-imm
				ctrl.alumux2_sel    = 3'd5;
				ctrl.aluop          = alu_add;
			end

			op_jalr: begin
				ctrl.load_regfile   = 1'b1;
				ctrl.regfilemux_sel = 3'd4;
				ctrl.pcmux_sel      = 1'b1; // rs1 + i-imm
				ctrl.aluop          = alu_add;
			end

			op_br: begin
				ctrl.alumux1_sel = 1'b1; // target is pc + b-imm
				ctrl.alumux2_sel = 3'd2;
				ctrl.aluop       = alu_add;
			end

			op_load: begin
				ctrl.load_regfile   = 1'b1;
				ctrl.regfilemux_sel = 3'd3;
				ctrl.aluop          = alu_add;
				ctrl.read_b         = 1'b1;
				case (load_funct3_t'(funct3))
					lb:  ctrl.load_type = 2'd1;
					lh:  ctrl.load_type = 2'd2;
					lbu: begin
						ctrl.load_type     = 2'd1;
						ctrl.load_unsigned = 1'b1;
					end
					lhu: begin
						ctrl.load_type     = 2'd2;
						ctrl.load_unsigned = 1'b1;
					end
					default: ctrl.load_type = 2'd0; // lw
				endcase
			end

			op_store: begin
				ctrl.alumux2_sel = 3'd3;
				ctrl.aluop       = alu_add;
				ctrl.write       = 1'b1;
				case (store_funct3_t'(funct3)) // size drives the byte mask later
					sb:      ctrl.store_type = 2'd1;
					sh:      ctrl.store_type = 2'd2;
					default: ctrl.store_type = 2'd0;
				endcase
			end

			op_imm: begin
				ctrl.load_regfile = 1'b1;
				case (arith_funct3_t'(funct3))
					slt: begin
						ctrl.cmpop          = blt;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel     = 1'b1; // compare against i-imm
					end
					sltu: begin
						ctrl.cmpop          = bltu;
						ctrl.regfilemux_sel = 3'd1;
						ctrl.cmpmux_sel     = 1'b1;
					end
					sr: begin
						if (funct7 == 7'b0100000) begin
							ctrl.aluop = alu_sra;
						end else begin
							ctrl.aluop = alu_srl;
						end
					end
					default: ctrl.aluop = alu_ops'(funct3);
				endcase
			end

			op_reg: begin
				ctrl.load_regfile = 1'b1;
				ctrl.alumux2_sel  = 3'd4;
				case (arith_funct3_t'(funct3))
					add: begin
						if (funct7 == 7'b0100000) begin
							ctrl.aluop = alu_sub;
						end else begin
							ctrl.aluop = alu_add;
						end
					end
					slt: begin
						ctrl.cmpop          = blt;
						ctrl.regfilemux_sel = 3'd1;
					end
					sltu: begin
						ctrl.cmpop          = bltu;
						ctrl.regfilemux_sel = 3'd1;
					end
					sr: begin
						if (funct7 == 7'b0100000) begin
							ctrl.aluop = alu_sra;
						end else begin
							ctrl.aluop = alu_srl;
						end
					end
					default: ctrl.aluop = alu_ops'(funct3);
				endcase
			end

			default: ctrl = '0; // unknown opcode retires as a no-op
		endcase
	end

endmodule : control_rom

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv32i_config.svh"

module regfile (
	input  wire logic                 clk,
	input  wire logic                 rst_n,
	input  wire rv32i_types::rf_wr_t   rf_wr,
	input  wire rv32i_types::reg_idx_t rs1,
	input  wire rv32i_types::reg_idx_t rs2,
	output rv32i_types::word_t         rs1_val,
	output rv32i_types::word_t         rs2_val
);
	import rv32i_types::*;

	word_t regs [`RF_COUNT]; // entry 0 is never written

	always_ff @(posedge clk) begin
		if (rf_wr.we && rf_wr.rd != '0) begin
			regs[rf_wr.rd] <= rf_wr.data;
		end
	end

	// x0 reads zero and a same-cycle write wins over the stored value
	assign rs1_val = (rs1 == '0) ? '0 :
		(rf_wr.we && rf_wr.rd == rs1) ? rf_wr.data : regs[rs1];
	assign rs2_val = (rs2 == '0) ? '0 :
		(rf_wr.we && rf_wr.rd == rs2) ? rf_wr.data : regs[rs2];

	// the execute stage must already have filtered out x0 writes
	a_no_x0_write: assert property (
		@(posedge clk) disable iff (!rst_n)
		rf_wr.we |-> rf_wr.rd != '0
	) else $error("register write aimed at x0");

endmodule : regfile

`default_nettype wire

/* verilog/decode_stage.sv */
`default_nettype none
`timescale 1ns/1ps

module decode_stage (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	input  wire logic                    in_valid,
	output logic                         in_ready,
	input  wire rv32i_types::instr_in_t  in,
	input  wire logic                    advance,
	output rv32i_types::reg_idx_t        rs1,
	output rv32i_types::reg_idx_t        rs2,
	input  wire rv32i_types::word_t      rs1_val,
	input  wire rv32i_types::word_t      rs2_val,
	output logic                         dx_valid,
	output rv32i_types::dx_t             dx
);
	import rv32i_types::*;

	logic [31:0]       instr;
	rv32i_opcode       opcode;
	rv32i_control_word ctrl;
	dx_t               dx_nxt;

	assign instr    = in.instr;
	assign opcode   = rv32i_opcode'(instr[6:0]);
	assign in_ready = advance; // accept whenever the dx slot moves on
	assign rs1      = instr[19:15];
	assign rs2      = instr[24:20];

	control_rom control_rom_i (
		.opcode (opcode),
		.funct3 (instr[14:12]),
		.funct7 (instr[31:25]),
		.ctrl   (ctrl)
	);

	always_comb begin
		dx_nxt.pc      = in.pc;
		dx_nxt.ctrl    = ctrl;
		dx_nxt.rs1_val = rs1_val;
		dx_nxt.rs2_val = rs2_val;
		dx_nxt.rd      = instr[11:7];
		// every immediate format is built each cycle
		dx_nxt.i_imm   = {{21{instr[31]}}, instr[30:20]};
		dx_nxt.s_imm   = {{21{instr[31]}}, instr[30:25], instr[11:7]};
		dx_nxt.b_imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		dx_nxt.u_imm   = {instr[31:12], 12'h000};
		dx_nxt.j_imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dx_valid <= 1'b0;
		end else if (advance) begin
			dx_valid <= in_valid; // bubble when nothing is offered
		end
	end

	always_ff @(posedge clk) begin
		if (advance && in_valid) begin
			dx <= dx_nxt;
		end
	end

	// a stalled instruction must sit unchanged until execute takes it
	a_dx_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		dx_valid && !advance |=> dx_valid && $stable(dx)
	) else $error("dx record changed while stalled");

endmodule : decode_stage

`default_nettype wire

/* verilog/exec_unit.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv32i_config.svh"

module exec_unit (
	input  wire logic             clk,
	input  wire logic             rst_n,
	input  wire logic             dx_valid,
	input  wire rv32i_types::dx_t dx,
	output logic                  advance,
	output rv32i_types::rf_wr_t   rf_wr,
	output logic                  out_valid,
	input  wire logic             out_ready,
	output rv32i_types::retire_t  out
);
	import rv32i_types::*;

	word_t      alu_a, alu_b, alu_out;
	word_t      cmp_b, wb_val, pc_plus4, jump_target;
	logic       br_en, rd_we;
	logic [3:0] wmask;
	word_t      wdata;
	retire_t    ret_nxt;

	assign advance  = !out_valid || out_ready;
	assign pc_plus4 = dx.pc + word_t'(4);

	assign alu_a = dx.ctrl.alumux1_sel ? dx.pc : dx.rs1_val;
	always_comb begin
		case (dx.ctrl.alumux2_sel)
			3'd1:    alu_b = dx.u_imm;
			3'd2:    alu_b = dx.b_imm;
			3'd3:    alu_b = dx.s_imm;
			3'd4:    alu_b = dx.rs2_val;
			3'd5:    alu_b = dx.j_imm;
			default: alu_b = dx.i_imm;
		endcase
	end

	always_comb begin
		unique case (dx.ctrl.aluop)
			alu_add: alu_out = alu_a + alu_b;
			alu_sll: alu_out = alu_a << alu_b[4:0];
			alu_sra: alu_out = word_t'($signed(alu_a) >>> alu_b[4:0]);
			alu_sub: alu_out = alu_a - alu_b;
			alu_xor: alu_out = alu_a ^ alu_b;
			alu_srl: alu_out = alu_a >> alu_b[4:0];
			alu_or:  alu_out = alu_a | alu_b;
			alu_and: alu_out = alu_a & alu_b;
		endcase
	end

	// shared by branches and slt/sltu
	assign cmp_b = dx.ctrl.cmpmux_sel ? dx.i_imm : dx.rs2_val;
	always_comb begin
		case (dx.ctrl.cmpop)
			beq:     br_en = dx.rs1_val == cmp_b;
			bne:     br_en = dx.rs1_val != cmp_b;
			blt:     br_en = $signed(dx.rs1_val) < $signed(cmp_b);
			bge:     br_en = $signed(dx.rs1_val) >= $signed(cmp_b);
			bltu:    br_en = dx.rs1_val < cmp_b;
			bgeu:    br_en = dx.rs1_val >= cmp_b;
			default: br_en = 1'b0;
		endcase
	end

	always_comb begin
		case (dx.ctrl.regfilemux_sel)
			3'd0:    wb_val = alu_out;
			3'd1:    wb_val = word_t'(br_en);
			3'd2:    wb_val = dx.u_imm;
			3'd4:    wb_val = pc_plus4;
			default: wb_val = '0; // load data is filled in outside the core
		endcase
	end

	assign jump_target = {alu_out[`XLEN-1:1], alu_out[0] & (dx.ctrl.opcode != op_jalr)};

	// store lanes and byte mask from the low address bits
	always_comb begin
		case (dx.ctrl.store_type)
			2'd1: begin
				wdata = {4{dx.rs2_val[7:0]}};
				wmask = 4'b0001 << alu_out[1:0];
			end
			2'd2: begin
				wdata = {2{dx.rs2_val[15:0]}};
				wmask = alu_out[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				wdata = dx.rs2_val;
				wmask = 4'b1111;
			end
		endcase
	end

	assign rd_we = dx.ctrl.load_regfile && dx.ctrl.opcode != op_load && dx.rd != '0;

	always_comb begin
		ret_nxt.pc            = dx.pc;
		ret_nxt.next_pc       = dx.ctrl.pcmux_sel ? jump_target :
			(dx.ctrl.opcode == op_br && br_en) ? alu_out : pc_plus4;
		ret_nxt.rd            = dx.rd;
		ret_nxt.rd_we         = rd_we;
		ret_nxt.rd_wdata      = wb_val;
		ret_nxt.mem_read      = dx.ctrl.read_b;
		ret_nxt.mem_write     = dx.ctrl.write;
		ret_nxt.mem_addr      = alu_out;
		ret_nxt.mem_wdata     = wdata;
		ret_nxt.mem_wmask     = dx.ctrl.write ? wmask : 4'b0000;
		ret_nxt.load_type     = dx.ctrl.load_type;
		ret_nxt.load_unsigned = dx.ctrl.load_unsigned;
	end

	// write back on the same edge the instruction retires
	assign rf_wr.we   = advance && dx_valid && rd_we;
	assign rf_wr.rd   = dx.rd;
	assign rf_wr.data = wb_val;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (advance) begin
			out_valid <= dx_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance && dx_valid) begin
			out <= ret_nxt;
		end
	end

	a_out_hold: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out)
	) else $error("retire record changed under back-pressure");

	a_store_mask: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid && out.mem_write |-> out.mem_wmask != 4'b0000
	) else $error("store retired with an empty byte mask");

endmodule : exec_unit

`default_nettype wire

/* verilog/rv32i_exec_top.sv */
`default_nettype none
`timescale 1ns/1ps

module rv32i_exec_top (
	input  wire logic                   clk,
	input  wire logic                   rst_n,
	input  wire logic                   in_valid,
	output logic                        in_ready,
	input  wire rv32i_types::instr_in_t in,
	output logic                        out_valid,
	input  wire logic                   out_ready,
	output rv32i_types::retire_t        out
);
	import rv32i_types::*;

	dx_t      dx;
	logic     dx_valid;
	logic     advance;
	rf_wr_t   rf_wr;
	reg_idx_t rs1_idx, rs2_idx;
	word_t    rs1_val, rs2_val;

	decode_stage decode_stage_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.in       (in),
		.advance  (advance),
		.rs1      (rs1_idx),
		.rs2      (rs2_idx),
		.rs1_val  (rs1_val),
		.rs2_val  (rs2_val),
		.dx_valid (dx_valid),
		.dx       (dx)
	);

	regfile regfile_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.rf_wr   (rf_wr),
		.rs1     (rs1_idx),
		.rs2     (rs2_idx),
		.rs1_val (rs1_val),
		.rs2_val (rs2_val)
	);

	exec_unit exec_unit_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.dx_valid  (dx_valid),
		.dx        (dx),
		.advance   (advance),
		.rf_wr     (rf_wr),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out)
	);

endmodule : rv32i_exec_top

`default_nettype wire

/* verif/tb_rv32i_exec.sv */
`default_nettype none
`timescale 1ns/1ps

`include "rv32i_config.svh"

module tb_rv32i_exec;
	import rv32i_types::*;

	logic      clk;
	logic      rst_n;
	logic      in_valid;
	logic      in_ready;
	instr_in_t in;
	logic      out_valid;
	logic      out_ready;
	retire_t   out;

	word_t   shadow [`RF_COUNT]; // reference copy of the integer registers
	retire_t exp_q [$];
	retire_t exp_head = '0;
	retire_t predicted;
	logic    head_valid = 1'b0;
	logic    match_ok;
	word_t   pc_next = 32'h0000_1000;
	int      ready_pct = 100;
	int      errors = 0;
	int      timeouts = 0;
	int      issued = 0;
	int      retired = 0;

	rv32i_exec_top rv32i_exec_top_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in        (in),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out       (out)
	);

	function automatic logic [31:0] r_type(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] i_type(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] s_type(input logic [11:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input logic [12:0] imm, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input logic [19:0] imm, input reg_idx_t rd,
		input logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] j_type(input logic [20:0] imm, input reg_idx_t rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	// integer result by funct3 where alt picks sub and sra
	function automatic word_t alu_ref(input logic [2:0] f3, input logic alt,
		input word_t x, input word_t y);
		case (f3)
			3'b000:  return alt ? x - y : x + y;
			3'b001:  return x << y[4:0];
			3'b010:  return word_t'($signed(x) < $signed(y));
			3'b011:  return word_t'(x < y);
			3'b100:  return x ^ y;
			3'b101:  return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
			3'b110:  return x | y;
			default: return x & y;
		endcase
	endfunction

	// expected retire record from the ISA rules and the shadow registers
	function automatic retire_t predict(input word_t pc, input logic [31:0] ins);
		retire_t r;
		logic [2:0] f3;
		word_t a, b, imm_i, imm_s, imm_b, imm_u, imm_j;
		logic taken;
		f3    = ins[14:12];
		a     = shadow[ins[19:15]];
		b     = shadow[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		imm_u = {ins[31:12], 12'h000};
		imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
		r = '0;
		r.pc      = pc;
		r.next_pc = pc + 32'd4;
		r.rd      = ins[11:7];
		case (ins[6:0])
			7'b0110111: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = imm_u;
			end
			7'b0010111: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = pc + imm_u;
			end
			7'b1101111: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = pc + 32'd4;
				r.next_pc  = pc + imm_j;
			end
			7'b1100111: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = pc + 32'd4;
				r.next_pc  = (a + imm_i) & 32'hffff_fffe;
			end
			7'b1100011: begin
				case (f3)
					3'b000:  taken = a == b;
					3'b001:  taken = a != b;
					3'b100:  taken = $signed(a) < $signed(b);
					3'b101:  taken = $signed(a) >= $signed(b);
					3'b110:  taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) begin
					r.next_pc = pc + imm_b;
				end
			end
			7'b0000011: begin
				r.mem_read      = 1'b1;
				r.mem_addr      = a + imm_i;
				r.load_type     = (f3[1:0] == 2'b00) ? 2'd1 : (f3[1:0] == 2'b01) ? 2'd2 : 2'd0;
				r.load_unsigned = f3[2];
			end
			7'b0100011: begin
				r.mem_write = 1'b1;
				r.mem_addr  = a + imm_s;
				case (f3[1:0])
					2'b00: begin
						r.mem_wdata = {4{b[7:0]}};
						case (r.mem_addr[1:0])
							2'd0:    r.mem_wmask = 4'b0001;
							2'd1:    r.mem_wmask = 4'b0010;
							2'd2:    r.mem_wmask = 4'b0100;
							default: r.mem_wmask = 4'b1000;
						endcase
					end
					2'b01: begin
						r.mem_wdata = {2{b[15:0]}};
						r.mem_wmask = r.mem_addr[1] ? 4'b1100 : 4'b0011;
					end
					default: begin
						r.mem_wdata = b;
						r.mem_wmask = 4'b1111;
					end
				endcase
			end
			7'b0010011: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = alu_ref(f3, f3 == 3'b101 && ins[30], a, imm_i);
			end
			7'b0110011: begin
				r.rd_we    = 1'b1;
				r.rd_wdata = alu_ref(f3, ins[30], a, b);
			end
			default: ; // unknown opcode has no effect
		endcase
		if (r.rd == '0) begin
			r.rd_we = 1'b0;
		end
		return r;
	endfunction

	// fields without meaning for this instruction are not compared
	function automatic logic record_ok(input retire_t got, input retire_t exp);
		logic ok;
		ok = got.pc == exp.pc && got.next_pc == exp.next_pc && got.rd_we == exp.rd_we &&
			got.mem_read == exp.mem_read && got.mem_write == exp.mem_write &&
			got.mem_wmask == exp.mem_wmask && got.load_type == exp.load_type &&
			got.load_unsigned == exp.load_unsigned;
		if (exp.rd_we || exp.mem_read) begin
			ok = ok && got.rd == exp.rd;
		end
		if (exp.rd_we) begin
			ok = ok && got.rd_wdata == exp.rd_wdata;
		end
		if (exp.mem_read || exp.mem_write) begin
			ok = ok && got.mem_addr == exp.mem_addr;
		end
		if (exp.mem_write) begin
			ok = ok && got.mem_wdata == exp.mem_wdata;
		end
		return ok;
	endfunction

	function automatic logic [31:0] random_instr();
		reg_idx_t rd, rs1, rs2;
		logic [2:0] f3;
		logic [11:0] imm;
		int idx;
		rd  = reg_idx_t'($urandom);
		rs1 = reg_idx_t'($urandom);
		rs2 = reg_idx_t'($urandom);
		f3  = 3'($urandom);
		imm = 12'($urandom);
		case ($urandom_range(0, 9))
			0, 1: return r_type(((f3 == 3'b000 || f3 == 3'b101) && $urandom_range(0, 1) == 1) ?
				7'b0100000 : 7'b0000000, rs2, rs1, f3, rd);
			2, 3: begin
				if (f3 == 3'b001) begin
					imm = {7'b0000000, imm[4:0]};
				end else if (f3 == 3'b101) begin
					imm = {($urandom_range(0, 1) == 1) ? 7'b0100000 : 7'b0000000, imm[4:0]};
				end
				return i_type(imm, rs1, f3, rd, op_imm);
			end
			4: return u_type(20'($urandom), rd, ($urandom_range(0, 1) == 1) ? op_lui : op_auipc);
			5: return j_type(21'($urandom), rd);
			6: return i_type(imm, rs1, 3'b000, rd, op_jalr);
			7: begin
				idx = $urandom_range(0, 5);
				return b_type(13'($urandom), ($urandom_range(0, 2) == 0) ? rs1 : rs2, rs1,
					(idx < 2) ? 3'(idx) : 3'(idx + 2));
			end
			8: begin
				idx = $urandom_range(0, 4);
				return i_type(imm, rs1, (idx < 3) ? 3'(idx) : 3'(idx + 1), rd, op_load);
			end
			default: return s_type(imm, rs2, rs1, 3'($urandom_range(0, 2)));
		endcase
	endfunction

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		out_ready = 1'b0;
		forever begin
			@(negedge clk);
			out_ready = ($urandom_range(0, 99) < ready_pct);
		end
	end

	// scoreboard updated in program order on each handshake
	always @(posedge clk) begin
		if (rst_n) begin
			if (out_valid && out_ready) begin
				if (exp_q.size() > 0) begin
					void'(exp_q.pop_front());
				end
				retired = retired + 1;
			end
			if (in_valid && in_ready) begin
				predicted = predict(in.pc, in.instr);
				if (predicted.rd_we) begin
					shadow[predicted.rd] = predicted.rd_wdata;
				end
				exp_q.push_back(predicted);
				issued = issued + 1;
			end
			head_valid <= exp_q.size() > 0;
			exp_head   <= (exp_q.size() > 0) ? exp_q[0] : '0;
		end
	end

	assign match_ok = record_ok(out, exp_head);

	a_no_extra_retire: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready |-> head_valid)
	else begin
		errors = errors + 1;
		$display("error at %0d ns: retire with no instruction outstanding", $time);
	end

	a_retire_match: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && out_ready && head_valid |-> match_ok)
	else begin
		errors = errors + 1;
		$display("error at %0d ns: retire at pc %h differs, next_pc %h rd_wdata %h", $time,
			$sampled(out.pc), $sampled(out.next_pc), $sampled(out.rd_wdata));
	end

	a_out_stable: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_ready |=> out_valid && $stable(out))
	else begin
		errors = errors + 1;
		$display("error at %0d ns: retire record changed while stalled", $time);
	end

	task automatic send(input logic [31:0] ins);
		int waited;
		logic accepted;
		if (timeouts == 0) begin
			if ($urandom_range(0, 3) == 0) begin
				in_valid = 1'b0; // idle gap on the input side
				@(negedge clk);
			end
			in_valid = 1'b1;
			in.pc    = pc_next;
			in.instr = ins;
			waited   = 0;
			accepted = 1'b0;
			while (!accepted && waited < 200) begin
				@(posedge clk);
				accepted = in_ready;
				waited   = waited + 1;
				@(negedge clk);
			end
			in_valid = 1'b0;
			if (!accepted) begin
				timeouts = timeouts + 1;
				$display("timeout: instruction at pc %h was never accepted", pc_next);
			end
			pc_next = pc_next + 32'd4;
		end
	endtask

	task automatic run_program();
		int k;
		reg_idx_t r1, r2;
		logic [2:0] f3;
		for (k = 1; k < 32; k++) begin // known value in every register
			send(u_type(20'($urandom), reg_idx_t'(k), op_lui));
			send(i_type(12'($urandom), reg_idx_t'(k), 3'b000, reg_idx_t'(k), op_imm));
		end
		ready_pct = 80;
		for (k = 0; k < 30; k++) begin // dependent chain through x5
			case (k % 6)
				0: send(r_type(7'b0100000, reg_idx_t'(k + 1), 5'd5, 3'b000, 5'd5));
				1: send(r_type(7'b0100000, 5'd6, 5'd5, 3'b101, 5'd5));
				2: send(r_type(7'b0000000, 5'd7, 5'd5, 3'b101, 5'd5));
				3: send(r_type(7'b0000000, 5'd8, 5'd5, 3'b010, 5'd9));
				4: send(r_type(7'b0000000, 5'd5, 5'd9, 3'b011, 5'd5));
				default: send(i_type(12'($urandom), 5'd5, 3'b000, 5'd5, op_imm));
			endcase
		end
		for (k = 0; k < 8; k++) begin
			send(u_type(20'($urandom), reg_idx_t'($urandom), op_lui));
			send(u_type(20'($urandom), reg_idx_t'($urandom), op_auipc));
			send(j_type(21'($urandom), reg_idx_t'($urandom)));
			send(i_type(12'($urandom) | 12'h001, reg_idx_t'($urandom), 3'b000,
				reg_idx_t'($urandom), op_jalr)); // often an odd target
		end
		for (k = 0; k < 36; k++) begin // six conditions with equal operands once each
			r1 = reg_idx_t'($urandom_range(1, 31));
			r2 = (k % 6 == 0) ? r1 : reg_idx_t'($urandom_range(0, 31));
			f3 = (k / 6 < 2) ? 3'(k / 6) : 3'(k / 6 + 2);
			send(b_type(13'($urandom), r2, r1, f3));
		end
		for (k = 0; k < 12; k++) begin // every size at every byte offset
			send(s_type(12'(k % 4), reg_idx_t'($urandom_range(1, 31)), 5'd0, 3'(k / 4)));
		end
		for (k = 0; k < 20; k++) begin
			f3 = (k % 5 < 3) ? 3'(k % 5) : 3'(k % 5 + 1);
			send(i_type(12'($urandom), reg_idx_t'($urandom), f3, reg_idx_t'($urandom), op_load));
		end
		send(i_type(12'h07b, 5'd1, 3'b000, 5'd0, op_imm));
		send(u_type(20'habcde, 5'd0, op_lui));
		send(r_type(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd0));
		send(j_type(21'h000100, 5'd0));
		send({25'h0abcdef, 7'b0001111}); // fence is not decoded here
		send({25'h0123456, 7'b1110011});
		send(32'h0000_0000);
		send(32'hffff_ffff);
		send(r_type(7'b0000000, 5'd1, 5'd0, 3'b000, 5'd7)); // x7 = x0 + x1
		send(i_type(12'h000, 5'd0, 3'b110, 5'd8, op_imm));
		ready_pct = 100;
		repeat (100) send(random_instr());
		ready_pct = 60;
		repeat (150) send(random_instr());
		ready_pct = 25;
		repeat (100) send(random_instr());
	endtask

	initial begin
		int waited;
		void'($urandom(32'h8eb3));
		for (int i = 0; i < `RF_COUNT; i++) begin
			shadow[i] = '0;
		end
		rst_n    = 1'b0;
		in_valid = 1'b0;
		in       = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		run_program();
		waited = 0;
		while (retired != issued && waited < 500) begin
			@(negedge clk);
			waited = waited + 1;
		end
		if (retired != issued) begin
			timeouts = timeouts + 1;
			$display("timeout: %0d instructions never retired", issued - retired);
		end
		a_all_retired: assert (issued == retired && exp_q.size() == 0)
		else begin
			errors = errors + 1;
			$display("error at %0d ns: %0d issued, %0d retired", $time, issued, retired);
		end
		$display("errors: %0d, timeouts: %0d, retired %0d of %0d", errors, timeouts,
			retired, issued);
		if (errors == 0 && timeouts == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : tb_rv32i_exec

`default_nettype wire

/* sim.f */
+incdir+verilog
verilog/rv32i_types.sv
verilog/control_rom.sv
verilog/regfile.sv
verilog/decode_stage.sv
verilog/exec_unit.sv
verilog/rv32i_exec_top.sv
verif/tb_rv32i_exec.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_rv32i_exec
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
